// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := rv32_core_tb
FILELIST  := rv32_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    localparam int XLEN      = 32;           // register and data width
    localparam int NREGS     = 32;           // x0 to x31
    localparam int DIV_STEPS = 32;           // one quotient bit per step

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b                           // lui
    } alu_op_t;

    // same encoding as funct3 of the branches
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } br_op_t;

    typedef enum logic [1:0] {
        wb_alu  = 2'b00,
        wb_load = 2'b01,
        wb_pc4  = 2'b10,                     // link address
        wb_div  = 2'b11
    } wb_sel_t;

endpackage

`default_nettype wire

// File: divider/rv32_divider.sv
`default_nettype none

module rv32_divider #(
    parameter int DIV_STEPS = 32
) (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic                      i_start,
    input  logic                      i_signed,
    input  logic [rv32_pkg::XLEN-1:0] i_dividend,
    input  logic [rv32_pkg::XLEN-1:0] i_divisor,
    output logic [rv32_pkg::XLEN-1:0] o_quotient,
    output logic [rv32_pkg::XLEN-1:0] o_remainder,
    output logic                      o_done
);
    import rv32_pkg::*;

    localparam int CW = $clog2(DIV_STEPS + 1);

    logic [CW-1:0]   cnt;                        // steps left or zero when idle
    logic [XLEN-1:0] quo;                        // dividend bits shift out as quotient bits shift in
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dvsr;                       // divisor magnitude
    logic            neg_q;
    logic            neg_r;
    logic            dvsr_zero;
    logic [XLEN:0]   rem_sh;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] quo_next;
    logic [XLEN-1:0] rem_next;

    // one restoring step
    assign rem_sh   = {rem, quo[XLEN-1]};
    assign diff     = rem_sh - {1'b0, dvsr};
    assign quo_next = {quo[XLEN-2:0], ~diff[XLEN]};
    assign rem_next = diff[XLEN] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0];  // restore on borrow

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= (cnt == CW'(1));           // high in the cycle after the last step
            if (i_start) begin
                cnt <= CW'(DIV_STEPS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            quo       <= (i_signed && i_dividend[XLEN-1]) ? -i_dividend : i_dividend;
            rem       <= '0;
            dvsr      <= (i_signed && i_divisor[XLEN-1]) ? -i_divisor : i_divisor;
            neg_q     <= i_signed && (i_dividend[XLEN-1] ^ i_divisor[XLEN-1]);
            neg_r     <= i_signed && i_dividend[XLEN-1];  // remainder takes dividend sign
            dvsr_zero <= (i_divisor == '0);
        end else if (cnt != '0) begin
            quo <= quo_next;
            rem <= rem_next;
        end
        // signs fixed on the last step and held until the next start
        if (!i_start && cnt == CW'(1)) begin
            o_quotient  <= dvsr_zero ? '1 : (neg_q ? -quo_next : quo_next);
            o_remainder <= neg_r ? -rem_next : rem_next;
        end
    end

endmodule

`default_nettype wire

// File: rv32_core.f
common/rv32_pkg.sv
src/rv32_alu.sv
src/rv32_regfile.sv
src/rv32_pc_unit.sv
src/rv32_decoder.sv
divider/rv32_divider.sv
src/rv32_core.sv
verif/rv32_clk_gen.sv
verif/rv32_core_asserts.sv
verif/rv32_core_tb.sv

// File: src/rv32_alu.sv
`default_nettype none

module rv32_alu (
    input  rv32_pkg::alu_op_t         i_op,
    input  logic [rv32_pkg::XLEN-1:0] i_a,
    input  logic [rv32_pkg::XLEN-1:0] i_b,
    output logic [rv32_pkg::XLEN-1:0] o_result
);
    import rv32_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = i_b[4:0];                       // rs2 or the shamt field
    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;

    always_comb begin
        case (i_op)
            alu_add:    o_result = i_a + i_b;
            alu_sub:    o_result = i_a - i_b;
            alu_and:    o_result = i_a & i_b;
            alu_or:     o_result = i_a | i_b;
            alu_xor:    o_result = i_a ^ i_b;
            alu_sll:    o_result = i_a << shamt;
            alu_srl:    o_result = i_a >> shamt;
            alu_sra:    o_result = $signed(i_a) >>> shamt;
            alu_slt:    o_result = {{(XLEN-1){1'b0}}, lt_s};
            alu_sltu:   o_result = {{(XLEN-1){1'b0}}, lt_u};
            alu_pass_b: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv32_core.sv
`default_nettype none

module rv32_core (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic [31:0]               i_inst,
    input  logic [rv32_pkg::XLEN-1:0] i_rdata,
    output logic [rv32_pkg::XLEN-1:0] o_pc,
    output logic [rv32_pkg::XLEN-1:0] o_addr,
    output logic [rv32_pkg::XLEN-1:0] o_wdata,
    output logic                      o_wmem
);
    import rv32_pkg::*;

    logic [4:0]      rs1, rs2, rd;
    logic            wreg;
    alu_op_t         alu_op;
    logic            src_imm, src_pc;
    logic [XLEN-1:0] imm;
    logic            branch, jal, jalr;
    br_op_t          br_op;
    wb_sel_t         wb_sel;
    logic            div_start, div_signed, div_rem, div_done;
    logic            pc_hold;
    logic [XLEN-1:0] rs1_val, rs2_val;
    logic [XLEN-1:0] alu_a, alu_b, alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] quotient, remainder;
    logic [XLEN-1:0] wb_data;

    assign alu_a   = src_pc ? o_pc : rs1_val;    // auipc uses the pc
    assign alu_b   = src_imm ? imm : rs2_val;
    assign wb_data = (wb_sel == wb_load) ? i_rdata :
                     (wb_sel == wb_pc4)  ? pc_plus4 :
                     (wb_sel == wb_div)  ? (div_rem ? remainder : quotient) :
                                           alu_result;
    assign o_addr  = alu_result;
    assign o_wdata = rs2_val;

    rv32_decoder decoder_i (
        .clk(clk), .clrn(clrn), .i_inst(i_inst), .i_div_done(div_done),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_wreg(wreg), .o_alu_op(alu_op),
        .o_src_imm(src_imm), .o_src_pc(src_pc), .o_imm(imm), .o_branch(branch),
        .o_br_op(br_op), .o_jal(jal), .o_jalr(jalr), .o_wb_sel(wb_sel), .o_wmem(o_wmem),
        .o_div_start(div_start), .o_div_signed(div_signed), .o_div_rem(div_rem),
        .o_pc_hold(pc_hold)
    );

    rv32_regfile regfile_i (
        .clk(clk), .clrn(clrn), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd), .i_we(wreg),
        .i_wdata(wb_data), .o_rdata1(rs1_val), .o_rdata2(rs2_val)
    );

    rv32_alu alu_i (.i_op(alu_op), .i_a(alu_a), .i_b(alu_b), .o_result(alu_result));

    rv32_pc_unit pc_unit_i (
        .clk(clk), .clrn(clrn), .i_hold(pc_hold), .i_branch(branch), .i_br_op(br_op),
        .i_jal(jal), .i_jalr(jalr), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val),
        .i_imm(imm), .o_pc(o_pc), .o_pc_plus4(pc_plus4)
    );

    rv32_divider #(.DIV_STEPS(DIV_STEPS)) divider_i (
        .clk(clk), .clrn(clrn), .i_start(div_start), .i_signed(div_signed),
        .i_dividend(rs1_val), .i_divisor(rs2_val), .o_quotient(quotient),
        .o_remainder(remainder), .o_done(div_done)
    );

endmodule

`default_nettype wire

// File: src/rv32_decoder.sv
`default_nettype none

module rv32_decoder (
    input  logic                    clk,
    input  logic                    clrn,
    input  logic [31:0]             i_inst,
    input  logic                    i_div_done,
    output logic [4:0]              o_rs1,
    output logic [4:0]              o_rs2,
    output logic [4:0]              o_rd,
    output logic                    o_wreg,
    output rv32_pkg::alu_op_t       o_alu_op,
    output logic                    o_src_imm,
    output logic                    o_src_pc,
    output logic [31:0]             o_imm,
    output logic                    o_branch,
    output rv32_pkg::br_op_t        o_br_op,
    output logic                    o_jal,
    output logic                    o_jalr,
    output rv32_pkg::wb_sel_t       o_wb_sel,
    output logic                    o_wmem,
    output logic                    o_div_start,
    output logic                    o_div_signed,
    output logic                    o_div_rem,
    output logic                    o_pc_hold
);
    import rv32_pkg::*;

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t     alu_f3;                     // operation picked by funct3
    logic        rr_legal;
    logic        is_div;
    logic        div_issued;                 // divide in flight

    assign opcode = opcode_t'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rd   = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // funct7 is either zero or 0100000 on sub and sra
    assign rr_legal = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign is_div   = (opcode == opc_op) && (funct7 == 7'b0000001) && funct3[2];

    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
            3'b001:  alu_f3 = alu_sll;
            3'b010:  alu_f3 = alu_slt;
            3'b011:  alu_f3 = alu_sltu;
            3'b100:  alu_f3 = alu_xor;
            3'b101:  alu_f3 = funct7[5] ? alu_sra : alu_srl;
            3'b110:  alu_f3 = alu_or;
            default: alu_f3 = alu_and;
        endcase
    end

    always_comb begin
        o_wreg    = 1'b0;
        o_alu_op  = alu_add;
        o_src_imm = 1'b0;
        o_src_pc  = 1'b0;
        o_imm     = imm_i;
        o_branch  = 1'b0;
        o_jal     = 1'b0;
        o_jalr    = 1'b0;
        o_wb_sel  = wb_alu;
        o_wmem    = 1'b0;
        case (opcode)
            opc_op: begin
                if (funct7 == 7'b0000001) begin
                    o_wb_sel = wb_div;
                    o_wreg   = is_div && i_div_done;   // mul is not implemented
                end else begin
                    o_alu_op = alu_f3;
                    o_wreg   = rr_legal;
                end
            end
            opc_op_imm: begin
                o_alu_op  = alu_f3;
                o_src_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            opc_load: begin
                o_src_imm = 1'b1;
                o_wb_sel  = wb_load;
                o_wreg    = (funct3 == 3'b010);        // lw only
            end
            opc_store: begin
                o_imm     = imm_s;
                o_src_imm = 1'b1;
                o_wmem    = (funct3 == 3'b010);        // sw only
            end
            opc_branch: begin
                o_imm    = imm_b;
                o_branch = 1'b1;
            end
            opc_jal: begin
                o_imm    = imm_j;
                o_jal    = 1'b1;
                o_wb_sel = wb_pc4;
                o_wreg   = 1'b1;
            end
            opc_jalr: begin
                o_jalr   = (funct3 == 3'b000);
                o_wb_sel = wb_pc4;
                o_wreg   = (funct3 == 3'b000);
            end
            opc_lui: begin
                o_imm     = imm_u;
                o_alu_op  = alu_pass_b;
                o_src_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            opc_auipc: begin
                o_imm     = imm_u;
                o_src_pc  = 1'b1;
                o_src_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            default: ;
        endcase
    end

    assign o_br_op      = br_op_t'(funct3);
    assign o_div_start  = is_div && !div_issued;  // first cycle of the divide
    assign o_div_signed = !funct3[0];             // div and rem
    assign o_div_rem    = funct3[1];
    assign o_pc_hold    = is_div && !i_div_done;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            div_issued <= 1'b0;
        end else if (o_div_start) begin
            div_issued <= 1'b1;
        end else if (i_div_done) begin
            div_issued <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/rv32_pc_unit.sv
`default_nettype none

module rv32_pc_unit (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic                      i_hold,
    input  logic                      i_branch,
    input  rv32_pkg::br_op_t          i_br_op,
    input  logic                      i_jal,
    input  logic                      i_jalr,
    input  logic [rv32_pkg::XLEN-1:0] i_rs1_val,
    input  logic [rv32_pkg::XLEN-1:0] i_rs2_val,
    input  logic [rv32_pkg::XLEN-1:0] i_imm,
    output logic [rv32_pkg::XLEN-1:0] o_pc,
    output logic [rv32_pkg::XLEN-1:0] o_pc_plus4
);
    import rv32_pkg::*;

    logic            taken;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] pc_next;

    always_comb begin
        case (i_br_op)
            br_eq:   taken = (i_rs1_val == i_rs2_val);
            br_ne:   taken = (i_rs1_val != i_rs2_val);
            br_lt:   taken = $signed(i_rs1_val) < $signed(i_rs2_val);
            br_ge:   taken = $signed(i_rs1_val) >= $signed(i_rs2_val);
            br_ltu:  taken = i_rs1_val < i_rs2_val;
            br_geu:  taken = i_rs1_val >= i_rs2_val;
            default: taken = 1'b0;              // funct3 010 and 011 undefined
        endcase
    end

    assign o_pc_plus4 = o_pc + 32'd4;
    assign jalr_sum   = i_rs1_val + i_imm;

    always_comb begin
        if (i_jalr) begin
            pc_next = {jalr_sum[XLEN-1:1], 1'b0};  // bit 0 cleared
        end else if (i_jal || (i_branch && taken)) begin
            pc_next = o_pc + i_imm;
        end else begin
            pc_next = o_pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            o_pc <= '0;
        end else if (!i_hold) begin
            o_pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: src/rv32_regfile.sv
`default_nettype none

module rv32_regfile (
    input  logic                      clk,
    input  logic                      clrn,
    input  logic [4:0]                i_rs1,
    input  logic [4:0]                i_rs2,
    input  logic [4:0]                i_rd,
    input  logic                      i_we,
    input  logic [rv32_pkg::XLEN-1:0] i_wdata,
    output logic [rv32_pkg::XLEN-1:0] o_rdata1,
    output logic [rv32_pkg::XLEN-1:0] o_rdata2
);
    import rv32_pkg::*;

    logic [XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin   // x0 stays zero
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: verif/rv32_clk_gen.sv
`default_nettype none

module rv32_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_clrn
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_clrn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #(PERIOD / 4);                           // release away from both edges
        o_clrn = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/rv32_core_asserts.sv
`default_nettype none

module rv32_core_asserts (
    input logic                      clk,
    input logic                      clrn,
    input logic [rv32_pkg::XLEN-1:0] i_pc,
    input logic                      i_div_start,
    input logic                      i_div_done,
    input logic                      i_div_issued
);
    import rv32_pkg::*;

    int fail_count = 0;                          // failures seen so far

    pc_aligned: assert property (@(posedge clk) disable iff (!clrn) i_pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            fail_count++;
        end

    pc_after_reset: assert property (@(posedge clk) $rose(clrn) |-> i_pc == '0)
        else begin
            $error("pc is not zero in the first cycle after reset");
            fail_count++;
        end

    pc_held_in_divide: assert property (@(posedge clk) disable iff (!clrn)
        i_div_issued |-> $stable(i_pc))
        else begin
            $error("pc moved while a divide was in flight");
            fail_count++;
        end

    // done comes a fixed latency after the start strobe
    done_after_start: assert property (@(posedge clk) disable iff (!clrn)
        i_div_done |-> $past(i_div_start, DIV_STEPS + 1))
        else begin
            $error("divider done without a start at the right distance");
            fail_count++;
        end

endmodule

bind rv32_core rv32_core_asserts asserts_i (
    .clk(clk), .clrn(clrn), .i_pc(o_pc), .i_div_start(div_start),
    .i_div_done(div_done), .i_div_issued(decoder_i.div_issued)
);

`default_nettype wire

// File: verif/rv32_core_tb.sv
`default_nettype none

module rv32_core_tb;

    localparam logic [31:0] NOP      = 32'h0000_0013;  // addi x0, x0, 0
    localparam int          SEED     = 32'h5ccf;
    localparam int          MARGIN   = 50;
    localparam int          DIV_HOLD = 34;             // cycles pc sits on a divide
    localparam int          IMEM_LEN = 512;

    logic        clk;
    logic        clrn;
    logic [31:0] inst;
    logic [31:0] rdata;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wmem;

    logic [31:0] imem [0:IMEM_LEN-1];
    bit          div_pc [0:IMEM_LEN-1];                // word holds a divide
    logic [31:0] dmem [0:255];
    int          prog_len = 0;
    int          n_div = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    logic [31:0] next_slot = 32'h100;                  // next free store address
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] held_pc = 32'hffff_fffc;
    int          held_cycles = 0;

    rv32_clk_gen #(.PERIOD(10), .RESET_CYCLES(4)) clk_gen_i (.o_clk(clk), .o_clrn(clrn));

    rv32_core dut_i (
        .clk(clk), .clrn(clrn), .i_inst(inst), .i_rdata(rdata),
        .o_pc(pc), .o_addr(addr), .o_wdata(wdata), .o_wmem(wmem)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return byte_addr ^ {byte_addr[15:0], byte_addr[31:16]} ^ 32'hd00d_f00d;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // div, divu, rem, remu by funct3
    function automatic logic [31:0] ref_div(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (b == 32'd0) begin
            return f3[1] ? a : 32'hffff_ffff;
        end
        if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return f3[1] ? 32'd0 : 32'h8000_0000;         // signed overflow
        end
        case (f3[1:0])
            2'd0: return sa / sb;
            2'd1: return a / b;
            2'd2: return sa % sb;
            default: return a % b;
        endcase
    endfunction

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_fail($sformatf("error at %0t: %s is %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic append_inst(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;                       // addi sign-extends the low part
        append_inst(u_type(upper[31:12], rd, 7'b0110111));
        append_inst(i_type(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic store_word(input logic [4:0] rs, input logic [31:0] value,
                              input bit expected);
        append_inst(s_type(next_slot[11:0], rs, 5'd0));
        if (expected) begin
            exp_addr.push_back(next_slot);
            exp_data.push_back(value);
        end
        next_slot += 4;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] slot;
        logic [31:0] here;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        // register and immediate operations, lui and auipc
        for (int r = 0; r < 2; r++) begin
            a = $urandom;
            b = $urandom;
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int k = 0; k < 10; k++) begin
                f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
                alt = (k >= 8);
                append_inst(r_type(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
                store_word(5'd3, ref_alu(f3, alt, a, b), 1'b1);
            end
            for (int k = 0; k < 9; k++) begin
                f3  = (k < 8) ? 3'(k) : 3'd5;
                alt = (k == 8);                         // srai
                imm = 12'($urandom);
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {alt ? 7'b0100000 : 7'b0000000, imm[4:0]};
                end
                append_inst(i_type(imm, 5'd1, f3, 5'd3, 7'b0010011));
                store_word(5'd3, ref_alu(f3, alt, a, {{20{imm[11]}}, imm}), 1'b1);
            end
            v = $urandom;
            append_inst(u_type(v[31:12], 5'd3, 7'b0110111));
            store_word(5'd3, {v[31:12], 12'h000}, 1'b1);
            here = 32'(prog_len * 4);
            append_inst(u_type(v[31:12], 5'd3, 7'b0010111));
            store_word(5'd3, here + {v[31:12], 12'h000}, 1'b1);
        end
        // store, load back, store again; then an untouched word
        v = $urandom;
        load_const(5'd4, v);
        slot = next_slot;
        store_word(5'd4, v, 1'b1);
        append_inst(i_type(slot[11:0], 5'd0, 3'b010, 5'd5, 7'b0000011));
        store_word(5'd5, v, 1'b1);
        append_inst(i_type(12'h3f0, 5'd0, 3'b010, 5'd6, 7'b0000011));
        store_word(5'd6, fill_word(32'h3f0), 1'b1);
        // branches skip a marker store when taken
        for (int p = 0; p < 3; p++) begin
            a = $urandom;
            v = $urandom;
            b = (p == 0) ? v : ((p == 1) ? a : ~a);
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int k = 0; k < 6; k++) begin
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                append_inst(b_type(13'd8, 5'd2, 5'd1, f3));
                store_word(5'd1, a, !ref_branch(f3, a, b));
            end
        end
        here = 32'(prog_len * 4);
        append_inst(j_type(21'd8, 5'd7));              // jal x7, +8
        store_word(5'd0, 32'd0, 1'b0);
        store_word(5'd7, here + 4, 1'b1);
        here = 32'(prog_len * 4);
        append_inst(u_type(20'd0, 5'd6, 7'b0010111));  // auipc x6, 0
        append_inst(i_type(12'd13, 5'd6, 3'b000, 5'd7, 7'b1100111));  // odd target
        store_word(5'd0, 32'd0, 1'b0);
        store_word(5'd7, here + 8, 1'b1);
        // divides on random pairs, then divide by zero and overflow
        for (int p = 0; p < 5; p++) begin
            v = $urandom;
            a = (p == 4) ? 32'h8000_0000 : $urandom;
            b = (p == 3) ? 32'd0 : ((p == 4) ? 32'hffff_ffff : v >> (p * 10));
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int k = 4; k < 8; k++) begin
                div_pc[prog_len] = 1'b1;
                n_div++;
                append_inst(r_type(7'b0000001, 5'd2, 5'd1, 3'(k), 5'd3));
                store_word(5'd3, ref_div(3'(k), a, b), 1'b1);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(32'(i * 4));
        end
        build_program();
        cycle_limit = prog_len + DIV_HOLD * n_div + MARGIN;
        inst  = NOP;
        rdata = '0;
        forever begin
            @(negedge clk);
            inst = (clrn && pc[31:2] < prog_len) ? imem[pc[10:2]] : NOP;
            #1;
            rdata = dmem[addr[9:2]];                    // load data follows the address
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_fail($sformatf("timeout: program did not finish within %0d cycles",
                                     cycle_limit));
        end else if (clrn && wmem) begin
            dmem[addr[9:2]] = wdata;
            if (exp_addr.size() == 0) begin
                stop_with_fail($sformatf("store to %h at %0t was not expected", addr, $time));
            end else begin
                compare_value("store address", addr, exp_addr.pop_front());
                compare_value("store data", wdata, exp_data.pop_front());
            end
        end
    end

    // how long pc stays on each address
    always @(negedge clk) begin
        if (clrn) begin
            if (pc == held_pc) begin
                held_cycles++;
            end else begin
                if (div_pc[held_pc[10:2]]) begin
                    compare_value("divide hold cycles", 32'(held_cycles), 32'(DIV_HOLD));
                end
                held_pc     = pc;
                held_cycles = 1;
            end
        end
    end

    initial begin
        @(posedge clrn);
        do begin
            @(negedge clk);
        end while (pc != 32'(prog_len * 4));
        if (exp_addr.size() != 0) begin
            stop_with_fail($sformatf("%0d expected stores never happened", exp_addr.size()));
        end else if (dut_i.asserts_i.fail_count != 0) begin
            stop_with_fail("assertions on the core reported failures");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire
